// File: Bender.yml
package:
  name: neo_palette_video

export_include_dirs:
  - include

sources:
  - files:
      - src/neo_video_pkg.sv
      - src/paletteLookup.sv
      - src/colorFifo.sv
      - src/colorExpander.sv
      - src/neoPaletteVideo.sv
  - target: test
    files:
      - verification/tb_neoPaletteVideo.sv

// File: build.f
+incdir+include
src/neo_video_pkg.sv
src/paletteLookup.sv
src/colorFifo.sv
src/colorExpander.sv
src/neoPaletteVideo.sv
verification/tb_neoPaletteVideo.sv

// File: include/neo_video_consts.svh
/*
 * Palette video constants
 * Widths, FIFO depth and pixel clock divider for the colour output path
 */

`ifndef NEO_VIDEO_CONSTS_SVH
`define NEO_VIDEO_CONSTS_SVH

// ========================================
// Palette RAM geometry
// ========================================

// Colour index within one bank, 4096 entries
`define NEO_PAL_INDEX_W 12

// Raw palette word as written by the CPU
`define NEO_PAL_WORD_W 16

// ========================================
// Colour output
// ========================================

// One expanded colour channel
`define NEO_CHAN_W 8

// Entries in the colour FIFO, power of two
`define NEO_FIFO_DEPTH 8

// 48 MHz cycles per pixel enable, 6 MHz dot clock
`define NEO_PIXEL_DIV 8

`endif

// File: src/colorExpander.sv
/*
 * Colour expander
 * Pixel enable divider, palette word to 8-bit RGB conversion and shadow
 */

`timescale 1ns/1ps

`include "neo_video_consts.svh"

module colorExpander (
	input  logic                       CLK_48M,
	input  logic                       nRESET,
	input  neo_video_pkg::colorEntry_t headData,
	input  logic                       fifoEmpty,
	output logic                       entryPop,
	output neo_video_pkg::colorChan_t  red,
	output neo_video_pkg::colorChan_t  green,
	output neo_video_pkg::colorChan_t  blue,
	output logic                       rgbValid,
	output logic                       pixelEnable
);

	import neo_video_pkg::*;

	localparam int DivW = $clog2(`NEO_PIXEL_DIV);
	localparam logic [DivW-1:0] LastDiv = DivW'(`NEO_PIXEL_DIV - 1);

	logic [DivW-1:0] pixDiv;
	colorChan_t      redNext;
	colorChan_t      greenNext;
	colorChan_t      blueNext;

	// One channel of the palette rule
	// Nibble, extra bit, nibble MSB, minus dark, clamp at 0
	function automatic colorChan_t expandChannel(
		input logic [3:0] nibble,
		input logic       extra,
		input logic       dark,
		input logic       shadow
	);
		logic [6:0] level6;
		colorChan_t full;
		level6 = {1'b0, nibble, extra, nibble[3]} - {6'd0, dark};
		// Borrow out of bit 6 means underflow
		full = level6[6] ? '0 : {level6[5:0], level6[4:3]};
		return shadow ? {1'b0, full[7:1]} : full;
	endfunction

	// ========================================
	// Conversion of the FIFO head
	// ========================================

	assign redNext   = expandChannel(headData[11:8], headData[14], headData[15],
		headData[`NEO_PAL_WORD_W]);
	assign greenNext = expandChannel(headData[7:4], headData[13], headData[15],
		headData[`NEO_PAL_WORD_W]);
	assign blueNext  = expandChannel(headData[3:0], headData[12], headData[15],
		headData[`NEO_PAL_WORD_W]);

	// Take the head only on a pixel slot
	assign entryPop = pixelEnable && !fifoEmpty;

	// ========================================
	// Pixel pacing and output registers
	// ========================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			pixDiv      <= '0;
			pixelEnable <= 1'b0;
			rgbValid    <= 1'b0;
			red         <= '0;
			green       <= '0;
			blue        <= '0;
		end else begin
			pixDiv      <= (pixDiv == LastDiv) ? '0 : pixDiv + 1'b1;
			pixelEnable <= (pixDiv == LastDiv);
			// Outputs hold between enables
			if (pixelEnable) begin
				rgbValid <= !fifoEmpty;
				red      <= fifoEmpty ? '0 : redNext;
				green    <= fifoEmpty ? '0 : greenNext;
				blue     <= fifoEmpty ? '0 : blueNext;
			end
		end
	end

endmodule

// File: src/colorFifo.sv
/*
 * Colour FIFO
 * Circular buffer of palette entries between lookup and expander
 */

`timescale 1ns/1ps

`include "neo_video_consts.svh"

module colorFifo #(
	parameter int Depth = `NEO_FIFO_DEPTH
) (
	input  logic                       CLK_48M,
	input  logic                       nRESET,
	input  logic                       entryPush,
	input  neo_video_pkg::colorEntry_t entryData,
	input  logic                       entryPop,
	output neo_video_pkg::colorEntry_t headData,
	output logic                       fifoEmpty,
	output logic [$clog2(Depth):0]     fifoLevel
);

	import neo_video_pkg::*;

	localparam int PtrW = $clog2(Depth);

	// Entry storage
	colorEntry_t fifoMem [0:Depth-1];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic            doPop;

	// ========================================
	// Status and head
	// ========================================

	assign fifoEmpty = (fifoLevel == '0);

	// Pop on empty is ignored
	assign doPop = entryPop && !fifoEmpty;

	// Head is read straight from the array
	assign headData = fifoMem[rdPtr];

	// Storage write, producer never overruns
	always_ff @(posedge CLK_48M) begin
		if (entryPush) begin
			fifoMem[wrPtr] <= entryData;
		end
	end

	// ========================================
	// Pointers and level
	// ========================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoLevel <= '0;
		end else begin
			// Power-of-two depth, pointers wrap on their own
			if (entryPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({entryPush, doPop})
				2'b10: fifoLevel <= fifoLevel + 1'b1;
				2'b01: fifoLevel <= fifoLevel - 1'b1;
				// Push with pop, or neither
				default: fifoLevel <= fifoLevel;
			endcase
		end
	end

endmodule

// File: src/neoPaletteVideo.sv
/*
 * Palette video top
 * Palette lookup feeding the colour FIFO, drained by the colour expander
 */

`timescale 1ns/1ps

`include "neo_video_consts.svh"

module neoPaletteVideo (
	input  logic                      CLK_48M,
	input  logic                      nRESET,
	// CPU palette write, no handshake
	input  logic                      palWrite,
	input  logic                      palWriteBank,
	input  neo_video_pkg::palIndex_t  palWriteAddr,
	input  neo_video_pkg::palWord_t   palWriteData,
	// Pixel index stream
	input  logic                      pixValid,
	output logic                      pixReady,
	input  neo_video_pkg::palIndex_t  pixIndex,
	input  logic                      pixBank,
	input  logic                      pixShadow,
	// Colour stream out
	output neo_video_pkg::colorChan_t red,
	output neo_video_pkg::colorChan_t green,
	output neo_video_pkg::colorChan_t blue,
	output logic                      rgbValid,
	output logic                      pixelEnable
);

	import neo_video_pkg::*;

	// Lookup to FIFO
	logic                             entryPush;
	colorEntry_t                      entryData;
	logic [$clog2(`NEO_FIFO_DEPTH):0] fifoLevel;

	// FIFO to expander
	colorEntry_t                      headData;
	logic                             fifoEmpty;
	logic                             entryPop;

	// ========================================
	// Producer, buffer, consumer
	// ========================================

	paletteLookup u_lookup (
		.CLK_48M      (CLK_48M),
		.nRESET       (nRESET),
		.palWrite     (palWrite),
		.palWriteBank (palWriteBank),
		.palWriteAddr (palWriteAddr),
		.palWriteData (palWriteData),
		.pixValid     (pixValid),
		.pixIndex     (pixIndex),
		.pixBank      (pixBank),
		.pixShadow    (pixShadow),
		.fifoLevel    (fifoLevel),
		.pixReady     (pixReady),
		.entryPush    (entryPush),
		.entryData    (entryData)
	);

	colorFifo #(
		.Depth (`NEO_FIFO_DEPTH)
	) u_fifo (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.entryPush (entryPush),
		.entryData (entryData),
		.entryPop  (entryPop),
		.headData  (headData),
		.fifoEmpty (fifoEmpty),
		.fifoLevel (fifoLevel)
	);

	colorExpander u_expander (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.headData    (headData),
		.fifoEmpty   (fifoEmpty),
		.entryPop    (entryPop),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.rgbValid    (rgbValid),
		.pixelEnable (pixelEnable)
	);

endmodule

// File: src/neo_video_pkg.sv
/*
 * Palette video package
 * Shared types for the palette lookup, colour FIFO and expander
 */

`include "neo_video_consts.svh"

package neo_video_pkg;

	// Colour index inside one palette bank
	typedef logic [`NEO_PAL_INDEX_W-1:0] palIndex_t;

	// Palette word layout
	// Bit 15 dark, bits 14..12 extra R/G/B LSB
	// Bits 11..8 red, 7..4 green, 3..0 blue
	typedef logic [`NEO_PAL_WORD_W-1:0] palWord_t;

	// Expanded colour channel
	typedef logic [`NEO_CHAN_W-1:0] colorChan_t;

	// FIFO entry
	// Shadow bit on top, palette word below
	typedef logic [`NEO_PAL_WORD_W:0] colorEntry_t;

	// What the single palette RAM port does this cycle
	typedef enum logic [1:0] {
		palOpIdle      = 2'd0,
		palOpCpuWrite  = 2'd1,
		palOpPixelRead = 2'd2
	} palOp_t;

endpackage

// File: src/paletteLookup.sv
/*
 * Palette lookup
 * Two-bank palette RAM with CPU write port and pipelined pixel reads
 */

`timescale 1ns/1ps

`include "neo_video_consts.svh"

module paletteLookup (
	input  logic                     CLK_48M,
	input  logic                     nRESET,
	input  logic                     palWrite,
	input  logic                     palWriteBank,
	input  neo_video_pkg::palIndex_t palWriteAddr,
	input  neo_video_pkg::palWord_t  palWriteData,
	input  logic                     pixValid,
	input  neo_video_pkg::palIndex_t pixIndex,
	input  logic                     pixBank,
	input  logic                     pixShadow,
	input  logic [$clog2(`NEO_FIFO_DEPTH):0] fifoLevel,
	output logic                     pixReady,
	output logic                     entryPush,
	output neo_video_pkg::colorEntry_t entryData
);

	import neo_video_pkg::*;

	localparam int AddrW  = `NEO_PAL_INDEX_W + 1;
	localparam int LevelW = $clog2(`NEO_FIFO_DEPTH) + 1;

	// Both banks in one array, bank flag is the address MSB
	palWord_t palRam [0:(1 << AddrW)-1];

	palOp_t           palOp;
	logic [AddrW-1:0] palAddr;
	palWord_t         ramQ;
	logic             rdValid;
	logic             rdShadow;
	logic [1:0]       inFlight;
	logic [LevelW:0]  committed;
	logic             hasRoom;

	// ========================================
	// Free space check
	// ========================================

	// Reads still in the pipe will land in the FIFO
	assign inFlight  = {1'b0, rdValid} + {1'b0, entryPush};
	assign committed = {1'b0, fifoLevel} + {{(LevelW-1){1'b0}}, inFlight};
	// One more pixel fits only if everything already owed still leaves a slot
	assign hasRoom   = committed < (LevelW+1)'(`NEO_FIFO_DEPTH);

	// ========================================
	// Port arbitration
	// ========================================

	always_comb begin
		// CPU always wins the RAM port
		if (palWrite) begin
			palOp = palOpCpuWrite;
		end else if (pixValid && hasRoom) begin
			palOp = palOpPixelRead;
		end else begin
			palOp = palOpIdle;
		end
	end

	// Ready only when the read actually happens this cycle
	assign pixReady = (palOp == palOpPixelRead);

	assign palAddr = (palOp == palOpCpuWrite) ? {palWriteBank, palWriteAddr}
		: {pixBank, pixIndex};

	// ========================================
	// Palette RAM and read pipeline
	// ========================================

	// Single port, one write or one read per cycle
	always_ff @(posedge CLK_48M) begin
		case (palOp)
			palOpCpuWrite: palRam[palAddr] <= palWriteData;
			palOpPixelRead: begin
				ramQ     <= palRam[palAddr];
				rdShadow <= pixShadow;
			end
			default: begin
			end
		endcase
	end

	// Output register, shadow rides along with the word
	always_ff @(posedge CLK_48M) begin
		entryData <= {rdShadow, ramQ};
	end

	// Valid pipe, stage 1 is the RAM read, stage 2 the push
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			rdValid   <= 1'b0;
			entryPush <= 1'b0;
		end else begin
			rdValid   <= (palOp == palOpPixelRead);
			entryPush <= rdValid;
		end
	end

endmodule

// File: verification/tb_neoPaletteVideo.sv
/*
 * Palette video testbench
 * Directed tests of conversion, shadow, banks, back-pressure and underrun
 */

`timescale 1ns/1ps

`include "neo_video_consts.svh"

module tb_neoPaletteVideo;

	import neo_video_pkg::*;

	localparam int HalfPeriod   = 4;
	localparam int WaitLimit    = 2000;
	// One pixel enable in every eight 48 MHz cycles
	localparam int EnablePeriod = 8;

	logic       CLK_48M      = 1'b0;
	logic       nRESET       = 1'b0;
	logic       palWrite     = 1'b0;
	logic       palWriteBank = 1'b0;
	palIndex_t  palWriteAddr = '0;
	palWord_t   palWriteData = '0;
	logic       pixValid     = 1'b0;
	palIndex_t  pixIndex     = '0;
	logic       pixBank      = 1'b0;
	logic       pixShadow    = 1'b0;
	logic       pixReady;
	colorChan_t red;
	colorChan_t green;
	colorChan_t blue;
	logic       rgbValid;
	logic       pixelEnable;

	// Reference model, shadow palette and expected colours in order
	palWord_t   modelPal [0:(1 << (`NEO_PAL_INDEX_W + 1))-1];
	colorChan_t expRed[$];
	colorChan_t expGreen[$];
	colorChan_t expBlue[$];
	logic       handshakeSeen = 1'b0;
	logic       enablePrev    = 1'b0;
	palOp_t     busOp;

	int colorErrors   = 0;
	int controlErrors = 0;
	int orderErrors   = 0;
	int timeoutErrors = 0;

	// Nibbles, extra bits, dark with colour, dark underflow
	palWord_t convWords [16] = '{16'h0000, 16'h0F00, 16'h00F0, 16'h000F, 16'h4000, 16'h2000,
		16'h1000, 16'h0888, 16'h0444, 16'h0222, 16'h0111, 16'h7FFF, 16'h8A5F, 16'h8111,
		16'hF000, 16'h8000};

	neoPaletteVideo dut (
		.CLK_48M      (CLK_48M),
		.nRESET       (nRESET),
		.palWrite     (palWrite),
		.palWriteBank (palWriteBank),
		.palWriteAddr (palWriteAddr),
		.palWriteData (palWriteData),
		.pixValid     (pixValid),
		.pixReady     (pixReady),
		.pixIndex     (pixIndex),
		.pixBank      (pixBank),
		.pixShadow    (pixShadow),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.rgbValid     (rgbValid),
		.pixelEnable  (pixelEnable)
	);

	always #HalfPeriod CLK_48M = ~CLK_48M;

	// ========================================
	// Reference model and compare tasks
	// ========================================

	// One channel of the palette rule, worked in integers
	function automatic colorChan_t modelChannel(input logic [3:0] nibble, input logic extra,
		input logic dark, input logic shadow);
		int level;
		int chan;
		level = int'(nibble) * 4 + int'(extra) * 2 + int'(nibble[3]) - int'(dark);
		chan  = (level < 0) ? 0 : level * 4 + (level / 8) % 4;
		if (shadow) begin
			chan = chan / 2;
		end
		return colorChan_t'(chan);
	endfunction

	task automatic expectPixel(input palWord_t word, input logic shadow);
		expRed.push_back(modelChannel(word[11:8], word[14], word[15], shadow));
		expGreen.push_back(modelChannel(word[7:4], word[13], word[15], shadow));
		expBlue.push_back(modelChannel(word[3:0], word[12], word[15], shadow));
	endtask

	task automatic checkColor(input string name, input colorChan_t gotR, input colorChan_t gotG,
		input colorChan_t gotB, input colorChan_t expR, input colorChan_t expG,
		input colorChan_t expB);
		if ({gotR, gotG, gotB} !== {expR, expG, expB}) begin
			colorErrors++;
			$display("[FAIL] %0t ns %s got %02h/%02h/%02h expected %02h/%02h/%02h", $time,
				name, gotR, gotG, gotB, expR, expG, expB);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			controlErrors++;
			$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Port activity just before each rising edge
	always @(negedge CLK_48M) begin
		#(HalfPeriod - 1);
		handshakeSeen = nRESET && pixValid && pixReady;
		busOp = palWrite ? palOpCpuWrite : (handshakeSeen ? palOpPixelRead : palOpIdle);
		if (nRESET) begin
			case (busOp)
				palOpCpuWrite: begin
					modelPal[{palWriteBank, palWriteAddr}] = palWriteData;
					// CPU owns the RAM port
					checkBit("pixReady", pixReady, 1'b0);
				end
				palOpPixelRead: expectPixel(modelPal[{pixBank, pixIndex}], pixShadow);
				default: begin
				end
			endcase
		end
	end

	// Colour output, checked on the cycle after each enable
	always @(negedge CLK_48M) begin
		if (nRESET && enablePrev) begin
			if (!rgbValid) begin
				checkColor("idle red/green/blue", red, green, blue, '0, '0, '0);
			end else if (expRed.size() == 0) begin
				orderErrors++;
				$display("Colour output at %0t ns with no pixel pending", $time);
			end else begin
				checkColor("red/green/blue", red, green, blue, expRed.pop_front(),
					expGreen.pop_front(), expBlue.pop_front());
			end
		end
		enablePrev = nRESET && pixelEnable;
	end

	// ========================================
	// Drivers and waits
	// ========================================

	task automatic writePalette(input logic bank, input palIndex_t addr, input palWord_t data);
		palWrite     = 1'b1;
		palWriteBank = bank;
		palWriteAddr = addr;
		palWriteData = data;
		@(negedge CLK_48M);
		palWrite = 1'b0;
	endtask

	task automatic sendPixel(input palIndex_t index, input logic bank, input logic shadow);
		int   cycles;
		logic accepted;
		pixValid  = 1'b1;
		pixIndex  = index;
		pixBank   = bank;
		pixShadow = shadow;
		cycles    = 0;
		accepted  = 1'b0;
		while (!accepted && cycles < WaitLimit) begin
			@(posedge CLK_48M);
			accepted = handshakeSeen;
			@(negedge CLK_48M);
			cycles++;
		end
		pixValid = 1'b0;
		if (!accepted) begin
			timeoutErrors++;
			$display("Timed out waiting for pixReady on index %03h", index);
		end
	endtask

	// Until every expected colour has left the DUT
	task automatic waitDrain();
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLK_48M);
			cycles++;
		end while (expRed.size() != 0 && cycles < WaitLimit);
		if (expRed.size() != 0) begin
			timeoutErrors++;
			$display("Timed out with %0d colours never output", expRed.size());
		end
		@(negedge CLK_48M);
	endtask

	task automatic waitEnable(output int cycles);
		cycles = 0;
		do begin
			@(negedge CLK_48M);
			cycles++;
		end while (!pixelEnable && cycles < WaitLimit);
		if (!pixelEnable) begin
			timeoutErrors++;
			$display("Timed out waiting for pixelEnable");
		end
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic resetTest();
		int cycles;
		nRESET = 1'b0;
		repeat (16) @(negedge CLK_48M);
		checkBit("rgbValid", rgbValid, 1'b0);
		checkBit("pixelEnable", pixelEnable, 1'b0);
		checkBit("pixReady", pixReady, 1'b0);
		checkColor("reset red/green/blue", red, green, blue, '0, '0, '0);
		nRESET = 1'b1;
		waitEnable(cycles);
		if (cycles != EnablePeriod) begin
			controlErrors++;
			$display("pixelEnable first rose %0d cycles after reset, not %0d", cycles,
				EnablePeriod);
		end
		// A stuck enable shows up as a one-cycle period
		repeat (3) begin
			waitEnable(cycles);
			if (cycles != EnablePeriod) begin
				controlErrors++;
				$display("pixelEnable period was %0d cycles, not %0d", cycles, EnablePeriod);
			end
		end
	endtask

	task automatic streamConv(input logic shadow);
		foreach (convWords[i]) begin
			sendPixel(palIndex_t'(12'h010 + i), 1'b0, shadow);
		end
		waitDrain();
	endtask

	task automatic conversionTest();
		foreach (convWords[i]) begin
			writePalette(1'b0, palIndex_t'(12'h010 + i), convWords[i]);
		end
		streamConv(1'b0);
	endtask

	task automatic bankTest();
		writePalette(1'b0, 12'h040, 16'h0F0F);
		writePalette(1'b1, 12'h040, 16'h70F0);
		writePalette(1'b0, 12'h041, 16'h1234);
		writePalette(1'b1, 12'h041, 16'hC321);
		for (int i = 0; i < 8; i++) begin
			sendPixel(palIndex_t'(12'h040 + (i / 2) % 2), (i % 2) == 1, 1'b0);
		end
		waitDrain();
	endtask

	task automatic randomPixel();
		pixIndex  = palIndex_t'(12'h100 + $urandom % 16);
		pixBank   = ($urandom % 2) == 1;
		pixShadow = ($urandom % 2) == 1;
	endtask

	// 40 pixels back to back, CPU writes to 0x800 and up mixed in
	task automatic burstTest();
		int   sent;
		int   cycles;
		logic accepted;
		for (int i = 0; i < 16; i++) begin
			writePalette(1'b0, palIndex_t'(12'h100 + i), palWord_t'($urandom));
			writePalette(1'b1, palIndex_t'(12'h100 + i), palWord_t'($urandom));
		end
		sent   = 0;
		cycles = 0;
		randomPixel();
		pixValid = 1'b1;
		while (sent < 40 && cycles < WaitLimit) begin
			palWrite     = ($urandom % 3) == 0;
			palWriteBank = ($urandom % 2) == 1;
			palWriteAddr = palIndex_t'(12'h800 + $urandom % 12'h800);
			palWriteData = palWord_t'($urandom);
			@(posedge CLK_48M);
			accepted = handshakeSeen;
			@(negedge CLK_48M);
			cycles++;
			if (accepted) begin
				sent++;
				randomPixel();
			end
		end
		palWrite = 1'b0;
		pixValid = 1'b0;
		if (sent < 40) begin
			timeoutErrors++;
			$display("Burst stalled after %0d of 40 pixels", sent);
		end
		waitDrain();
	endtask

	task automatic underrunTest();
		int cycles;
		waitEnable(cycles);
		@(negedge CLK_48M);
		checkBit("rgbValid", rgbValid, 1'b0);
		checkColor("underrun red/green/blue", red, green, blue, '0, '0, '0);
	endtask

	initial begin
		int seedValue;
		seedValue = $urandom(32'h6065_4647);
		resetTest();
		conversionTest();
		streamConv(1'b1);
		bankTest();
		burstTest();
		underrunTest();
		$display("Errors: color %0d, control %0d, order %0d, timeout %0d", colorErrors,
			controlErrors, orderErrors, timeoutErrors);
		if (colorErrors + controlErrors + orderErrors + timeoutErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Whole-run limit
	initial begin
		#200000;
		$display("Run stopped at the watchdog limit");
		$display("Simulation FAILED");
		$finish;
	end

endmodule
